/* Makefile */
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_iir_top
FILELIST   = iir_filter.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = all tests passed

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	rm -f $(LOG)
	$(SIM) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* iir_coef_bank.sv */
`timescale 1ns/1ns

module iir_coef_bank import iir_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      coef_we,
	input  coef_idx_t coef_idx,
	input  coef_t     coef,
	output coef_t     a1,
	output coef_t     a2,
	output coef_t     b0,
	output coef_t     b1,
	output coef_t     b2
);

	// each slot is written once per load and then held for the session
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			a1 <= '0;
			a2 <= '0;
			b0 <= '0;
			b1 <= '0;
			b2 <= '0;
		end
		else if (coef_we)
		begin
			case (coef_idx)
				IDX_A1: a1 <= coef;
				IDX_A2: a2 <= coef;
				IDX_B0: b0 <= coef;
				IDX_B1: b1 <= coef;
				IDX_B2: b2 <= coef;
				default: ;
			endcase
		end
	end

	// the sequencer only walks the five defined slots
	a_idx_range: assert property (
		@(posedge clk) disable iff (reset)
		coef_we |-> (int'(coef_idx) < NUM_COEFS)
	);

endmodule

/* iir_counters.sv */
`timescale 1ns/1ns

module iir_counters #(
	parameter int SAMPLE_COUNT  = 8,
	parameter int OUT_CREDITS   = 2,
	parameter int SETTLE_CYCLES = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic settle_start,
	input  logic sample_done,
	input  logic session_start,
	input  logic out_credit,
	input  logic out_credit_use,
	output logic settle_zero,
	output logic budget_zero,
	output logic out_credit_avail
);

	localparam int SETTLE_W = $clog2(SETTLE_CYCLES + 1);
	localparam int BUDGET_W = $clog2(SAMPLE_COUNT + 1);
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	logic [SETTLE_W-1:0] settle_cnt;
	logic [BUDGET_W-1:0] budget_cnt;
	logic [CREDIT_W-1:0] credit_cnt;

	// the settle state itself spends the last count, so load one less
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			settle_cnt <= '0;
		else if (settle_start)
			settle_cnt <= SETTLE_W'(SETTLE_CYCLES - 1);
		else if (settle_cnt != '0)
			settle_cnt <= settle_cnt - 1'b1;
	end

	// samples left in this session, spent when a sample is taken in
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			budget_cnt <= '0;
		else if (session_start)
			budget_cnt <= BUDGET_W'(SAMPLE_COUNT);
		else if (sample_done && (budget_cnt != '0))
			budget_cnt <= budget_cnt - 1'b1;
	end

	// output credits, a grant and a use in one cycle cancel out
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			credit_cnt <= '0;
		else
		begin
			case ({out_credit, out_credit_use})
				2'b10:
				begin
					if (credit_cnt != CREDIT_W'(OUT_CREDITS))
						credit_cnt <= credit_cnt + 1'b1;
				end
				2'b01: credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	assign settle_zero      = (settle_cnt == '0);
	assign budget_zero      = (budget_cnt == '0);
	assign out_credit_avail = (credit_cnt != '0);

	a_credit_max: assert property (
		@(posedge clk) disable iff (reset)
		credit_cnt <= CREDIT_W'(OUT_CREDITS)
	);

endmodule

/* iir_datapath.sv */
`timescale 1ns/1ns

module iir_datapath import iir_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  sample_t   in_data,
	input  coef_t     a1,
	input  coef_t     a2,
	input  coef_t     b0,
	input  coef_t     b1,
	input  coef_t     b2,
	iir_step_if.dp    step,
	output sample_t   out_data
);

	sample_t in_hold;
	sample_t x0;
	sample_t x1;
	sample_t x2;
	ystate_t y1;
	ystate_t y2;
	acc_t    fb_q;
	acc_t    ff_q;
	acc_t    acc;
	sample_t out_q;
	logic    acc_ready;

	// feedback products are kept at full width so the shift sees every bit
	logic signed [32:0] fb_sum;
	logic signed [32:0] fb_shift;
	acc_t               ff_sum;

	assign fb_sum   = a1 * y1 + a2 * y2;
	assign fb_shift = fb_sum >>> 3;
	// samples widen to the accumulator before the multiply, sum wraps at 27 bits
	assign ff_sum   = b0 * x0 + b1 * x1 + b2 * x2;

	// in_data is only valid in the in_valid cycle, take_sample comes one later
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			in_hold <= '0;
		else
			in_hold <= in_data;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			x0    <= '0;
			x1    <= '0;
			x2    <= '0;
			y1    <= '0;
			y2    <= '0;
			fb_q  <= '0;
			ff_q  <= '0;
			acc   <= '0;
			out_q <= '0;
		end
		else
		begin
			if (step.clear_history)
			begin
				x1 <= '0;
				x2 <= '0;
				y1 <= '0;
				y2 <= '0;
			end
			if (step.take_sample)
				x0 <= in_hold;
			if (step.sum_feedback)
				fb_q <= acc_t'(fb_shift);
			if (step.sum_feedforward)
				ff_q <= ff_sum;
			if (step.form_result)
				acc <= fb_q + ff_q;
			if (step.commit)
			begin
				out_q <= acc[26:19];
				x1    <= x0;
				x2    <= x1;
				y1    <= acc[26:11];
				y2    <= y1;
			end
		end
	end

	// result goes out during commit, then the register holds it
	assign out_data = step.commit ? sample_t'(acc[26:19]) : out_q;

	// acc holds a finished result that has not been committed yet
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			acc_ready <= 1'b0;
		else if (step.form_result)
			acc_ready <= 1'b1;
		else if (step.take_sample || step.commit)
			acc_ready <= 1'b0;
	end

	a_commit_order: assert property (
		@(posedge clk) disable iff (reset)
		step.commit |-> acc_ready
	);

endmodule

/* iir_filter.f */
iir_pkg.sv
iir_step_if.sv
iir_coef_bank.sv
iir_datapath.sv
iir_counters.sv
iir_sequencer.sv
iir_top.sv
tb_iir_top.sv

/* iir_pkg.sv */
package iir_pkg;

	// filter input and output samples, two's complement
	typedef logic signed [7:0] sample_t;

	// one filter coefficient as loaded by the host
	typedef logic signed [15:0] coef_t;

	// feedback history value, taken from acc bits 26..11
	typedef logic signed [15:0] ystate_t;

	// accumulator, every sum wraps at this width
	typedef logic signed [26:0] acc_t;

	// coefficient slot during a load
	// 0 = a1, 1 = a2, 2 = b0, 3 = b1, 4 = b2
	typedef logic [2:0] coef_idx_t;

	// coefficients per load
	localparam int NUM_COEFS = 5;

	// slot numbers in load order
	localparam coef_idx_t IDX_A1 = 3'd0;
	localparam coef_idx_t IDX_A2 = 3'd1;
	localparam coef_idx_t IDX_B0 = 3'd2;
	localparam coef_idx_t IDX_B1 = 3'd3;
	localparam coef_idx_t IDX_B2 = 3'd4;

endpackage

/* iir_sequencer.sv */
`timescale 1ns/1ns

module iir_sequencer import iir_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      coef_load,
	input  logic      in_valid,
	input  logic      out_credit_avail,
	input  logic      settle_zero,
	input  logic      budget_zero,
	output logic      in_credit,
	output logic      out_valid,
	output logic      done,
	output logic      coef_we,
	output coef_idx_t coef_idx,
	output logic      settle_start,
	output logic      sample_done,
	output logic      session_start,
	output logic      out_credit_use,
	iir_step_if.seq   step
);

	typedef enum logic [3:0] {
		s_idle,
		s_load,
		s_grant,
		s_wait_sample,
		s_take,
		s_feedback,
		s_feedforward,
		s_result,
		s_settle,
		s_wait_out,
		s_finish
	} state_t;

	state_t    state;
	state_t    next_state;
	coef_idx_t load_idx;
	logic      load_accept;

	// a load may start whenever no sample is in flight
	assign load_accept = coef_load &&
		((state == s_idle) || (state == s_grant) || (state == s_wait_sample));

	always_comb
	begin
		next_state = state;
		case (state)
			s_idle: next_state = s_idle;
			s_load:
			begin
				if (load_idx == coef_idx_t'(NUM_COEFS - 1))
					next_state = s_grant;
			end
			// the producer may answer in the same cycle as the credit
			s_grant: next_state = in_valid ? s_take : s_wait_sample;
			s_wait_sample:
			begin
				if (in_valid)
					next_state = s_take;
			end
			s_take:        next_state = s_feedback;
			s_feedback:    next_state = s_feedforward;
			s_feedforward: next_state = s_result;
			s_result:      next_state = s_settle;
			s_settle:
			begin
				if (settle_zero)
					next_state = s_wait_out;
			end
			s_wait_out:
			begin
				if (out_credit_avail)
					next_state = budget_zero ? s_finish : s_grant;
			end
			s_finish: next_state = s_idle;
			default:  next_state = s_idle;
		endcase
		if (load_accept)
			next_state = s_load;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= s_idle;
		else
			state <= next_state;
	end

	// slot 0 goes with coef_load, the rest follow while in s_load
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			load_idx <= '0;
		else if (load_accept)
			load_idx <= coef_idx_t'(1);
		else if (state == s_load)
			load_idx <= load_idx + 1'b1;
	end

	assign coef_we  = load_accept || (state == s_load);
	assign coef_idx = (state == s_load) ? load_idx : IDX_A1;

	assign in_credit      = (state == s_grant);
	assign out_valid      = (state == s_wait_out) && out_credit_avail;
	assign done           = (state == s_finish);
	assign out_credit_use = out_valid;
	assign session_start  = load_accept;
	assign settle_start   = (state == s_result);
	// budget counts samples taken in, so it is settled well before the output
	assign sample_done    = (state == s_take);

	assign step.clear_history   = load_accept;
	assign step.take_sample     = (state == s_take);
	assign step.sum_feedback    = (state == s_feedback);
	assign step.sum_feedforward = (state == s_feedforward);
	assign step.form_result     = (state == s_result);
	assign step.commit          = out_valid;

	a_state_legal: assert property (
		@(posedge clk) disable iff (reset)
		state inside {s_idle, s_load, s_grant, s_wait_sample, s_take, s_feedback,
			s_feedforward, s_result, s_settle, s_wait_out, s_finish}
	);

	// an output is only sent against a credit held in the counters
	a_out_credit: assert property (
		@(posedge clk) disable iff (reset)
		out_valid |-> out_credit_avail
	);

endmodule

/* iir_step_if.sv */
`timescale 1ns/1ns

// single-cycle step strobes from the sequencer to the datapath
interface iir_step_if;

	// zero x1, x2, y1 and y2 at session start
	logic clear_history;
	// x0 from the captured input sample
	logic take_sample;
	// shifted a1/a2 feedback sum
	logic sum_feedback;
	// b0/b1/b2 feedforward sum
	logic sum_feedforward;
	// acc from the two partial sums
	logic form_result;
	// output register, history shift, y1 from acc
	logic commit;

	modport seq (
		output clear_history,
		output take_sample,
		output sum_feedback,
		output sum_feedforward,
		output form_result,
		output commit
	);

	modport dp (
		input clear_history,
		input take_sample,
		input sum_feedback,
		input sum_feedforward,
		input form_result,
		input commit
	);

endinterface

/* iir_top.sv */
`timescale 1ns/1ns

module iir_top import iir_pkg::*; #(
	parameter int SAMPLE_COUNT  = 8,
	parameter int OUT_CREDITS   = 2,
	parameter int SETTLE_CYCLES = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    coef_load,
	input  coef_t   coef,
	input  logic    in_valid,
	input  sample_t in_data,
	input  logic    out_credit,
	output logic    in_credit,
	output logic    out_valid,
	output sample_t out_data,
	output logic    done
);

	iir_step_if step_bus ();

	logic      coef_we;
	coef_idx_t coef_idx;
	logic      settle_start;
	logic      sample_done;
	logic      session_start;
	logic      out_credit_use;
	logic      settle_zero;
	logic      budget_zero;
	logic      out_credit_avail;
	coef_t     a1;
	coef_t     a2;
	coef_t     b0;
	coef_t     b1;
	coef_t     b2;

	iir_sequencer u_sequencer (
		.clk              (clk),
		.reset            (reset),
		.coef_load        (coef_load),
		.in_valid         (in_valid),
		.out_credit_avail (out_credit_avail),
		.settle_zero      (settle_zero),
		.budget_zero      (budget_zero),
		.in_credit        (in_credit),
		.out_valid        (out_valid),
		.done             (done),
		.coef_we          (coef_we),
		.coef_idx         (coef_idx),
		.settle_start     (settle_start),
		.sample_done      (sample_done),
		.session_start    (session_start),
		.out_credit_use   (out_credit_use),
		.step             (step_bus.seq)
	);

	iir_counters #(
		.SAMPLE_COUNT  (SAMPLE_COUNT),
		.OUT_CREDITS   (OUT_CREDITS),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) u_counters (
		.clk              (clk),
		.reset            (reset),
		.settle_start     (settle_start),
		.sample_done      (sample_done),
		.session_start    (session_start),
		.out_credit       (out_credit),
		.out_credit_use   (out_credit_use),
		.settle_zero      (settle_zero),
		.budget_zero      (budget_zero),
		.out_credit_avail (out_credit_avail)
	);

	iir_coef_bank u_coef_bank (
		.clk      (clk),
		.reset    (reset),
		.coef_we  (coef_we),
		.coef_idx (coef_idx),
		.coef     (coef),
		.a1       (a1),
		.a2       (a2),
		.b0       (b0),
		.b1       (b1),
		.b2       (b2)
	);

	iir_datapath u_datapath (
		.clk      (clk),
		.reset    (reset),
		.in_data  (in_data),
		.a1       (a1),
		.a2       (a2),
		.b0       (b0),
		.b1       (b1),
		.b2       (b2),
		.step     (step_bus.dp),
		.out_data (out_data)
	);

endmodule

/* tb_iir_top.sv */
`timescale 1ns/1ns

module tb_iir_top import iir_pkg::*; ();

	localparam int SAMPLE_COUNT  = 8;
	localparam int OUT_CREDITS   = 2;
	localparam int SETTLE_CYCLES = 4;
	localparam int WAIT_LIMIT    = 60;

	logic    clk = 1'b0;
	logic    reset;
	logic    coef_load;
	coef_t   coef;
	logic    in_valid;
	sample_t in_data;
	logic    out_credit = 1'b0;
	logic    in_credit;
	logic    out_valid;
	sample_t out_data;
	logic    done;

	// consumer grants output credits only while this is set
	logic    credit_on;

	// reference copy of the coefficients and the filter history
	coef_t   m_a1;
	coef_t   m_a2;
	coef_t   m_b0;
	coef_t   m_b1;
	coef_t   m_b2;
	sample_t m_x1;
	sample_t m_x2;
	ystate_t m_y1;
	ystate_t m_y2;

	sample_t expect_q[$];
	sample_t exp_val;
	string   test_name;
	int      errors;
	int      checks;
	int      tests_run;
	int      tests_bad;
	int      err_at_start;
	bit      credit_held;
	bit      timed_out;

	iir_top #(
		.SAMPLE_COUNT  (SAMPLE_COUNT),
		.OUT_CREDITS   (OUT_CREDITS),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) UUT (
		.clk        (clk),
		.reset      (reset),
		.coef_load  (coef_load),
		.coef       (coef),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.done       (done)
	);

	always
		#5 clk = ~clk;

	// consumer side, one credit pulse every other cycle while enabled
	always @(negedge clk)
	begin
		if (credit_on && !out_credit)
			out_credit = 1'b1;
		else
			out_credit = 1'b0;
	end

	// every output is compared in order against the expected queue
	always @(negedge clk)
	begin
		if (!reset && out_valid)
		begin
			if (expect_q.size() == 0)
			begin
				$display("ERROR %s: out_valid with no sample pending, out_data %0d",
					test_name, out_data);
				errors++;
			end
			else
			begin
				exp_val = expect_q.pop_front();
				check_sample("out_data", exp_val, out_data);
			end
		end
	end

	task automatic check_sample(input string what, input sample_t exp, input sample_t act);
		checks++;
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input bit exp, input bit act);
		checks++;
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: %s expected %0b actual %0b", test_name, what, exp, act);
			errors++;
		end
	endtask

	// one filter step: feedback sum is exact before the shift, acc wraps at 27 bits
	function automatic sample_t filter_model(input sample_t x0);
		longint fb;
		longint ff;
		acc_t   acc;
		fb = longint'(m_a1) * longint'(m_y1) + longint'(m_a2) * longint'(m_y2);
		fb = fb >>> 3;
		ff = longint'(m_b0) * longint'(x0) + longint'(m_b1) * longint'(m_x1)
			+ longint'(m_b2) * longint'(m_x2);
		acc = acc_t'(fb + ff);
		m_x2 = m_x1;
		m_x1 = x0;
		m_y2 = m_y1;
		m_y1 = acc[26:11];
		return acc[26:19];
	endfunction

	function automatic coef_t rand_coef();
		return coef_t'($urandom);
	endfunction

	task automatic report_timeout(input string what);
		$display("ERROR %s: timed out waiting for %s", test_name, what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic load_coefs(input coef_t c_a1, c_a2, c_b0, c_b1, c_b2);
		if (timed_out)
			return;
		@(negedge clk);
		coef_load = 1'b1;
		coef = c_a1;
		@(negedge clk);
		coef_load = 1'b0;
		coef = c_a2;
		@(negedge clk);
		coef = c_b0;
		@(negedge clk);
		coef = c_b1;
		@(negedge clk);
		coef = c_b2;
		@(negedge clk);
		coef = '0;
		// credit comes right after the last coefficient
		check_flag("in_credit after load", 1'b1, in_credit);
		credit_held = in_credit;
		m_a1 = c_a1;
		m_a2 = c_a2;
		m_b0 = c_b0;
		m_b1 = c_b1;
		m_b2 = c_b2;
		m_x1 = '0;
		m_x2 = '0;
		m_y1 = '0;
		m_y2 = '0;
	endtask

	// wait for an input credit, then answer after delay cycles
	task automatic send_sample(input sample_t x, input int delay);
		int n;
		if (timed_out)
			return;
		n = 0;
		while (!credit_held && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			credit_held = in_credit;
			n++;
		end
		if (!credit_held)
		begin
			report_timeout("in_credit");
			return;
		end
		repeat (delay) @(negedge clk);
		in_valid = 1'b1;
		in_data = x;
		expect_q.push_back(filter_model(x));
		credit_held = 1'b0;
		@(negedge clk);
		in_valid = 1'b0;
		in_data = ~x;
	endtask

	task automatic wait_output(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit)
		begin
			@(negedge clk);
			seen = out_valid;
			n++;
		end
	endtask

	task automatic need_output();
		bit seen;
		if (timed_out)
			return;
		wait_output(WAIT_LIMIT, seen);
		if (!seen)
			report_timeout("out_valid");
	endtask

	task automatic wait_done();
		int n;
		bit seen;
		if (timed_out)
			return;
		seen = 1'b0;
		n = 0;
		while (!seen && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			seen = done;
			n++;
		end
		if (!seen)
			report_timeout("done");
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_at_start = errors;
	endtask

	task automatic end_test(input int num);
		@(negedge clk);
		check_flag("all outputs arrived", 1'b1, expect_q.size() == 0);
		tests_run++;
		if (errors == err_at_start)
			$display("test %0d %s: ok", num, test_name);
		else
		begin
			$display("test %0d %s: %0d errors", num, test_name, errors - err_at_start);
			tests_bad++;
		end
	endtask

	task automatic quiet_after_reset();
		int n_cr;
		int n_ov;
		int n_dn;
		begin_test("quiet after reset");
		n_cr = 0;
		n_ov = 0;
		n_dn = 0;
		repeat (20)
		begin
			@(negedge clk);
			n_cr += in_credit;
			n_ov += out_valid;
			n_dn += done;
		end
		check_flag("in_credit low", 1'b0, n_cr != 0);
		check_flag("out_valid low", 1'b0, n_ov != 0);
		check_flag("done low", 1'b0, n_dn != 0);
		end_test(1);
	endtask

	task automatic impulse_response();
		int i;
		begin_test("impulse response");
		credit_on <= 1'b1;
		// b0 alone gives a scaled copy of the impulse
		load_coefs(16'sd0, 16'sd0, 16'sd30000, 16'sd0, 16'sd0);
		for (i = 0; i < 4; i++)
		begin
			send_sample((i == 0) ? 8'sd127 : 8'sd0, 0);
			need_output();
		end
		// feedback keeps the response going after the impulse
		load_coefs(16'sd12000, -16'sd3000, 16'sd30000, 16'sd0, 16'sd0);
		for (i = 0; i < 6; i++)
		begin
			send_sample((i == 0) ? 8'sd127 : 8'sd0, i % 2);
			need_output();
		end
		end_test(2);
	endtask

	task automatic random_stream();
		int i;
		begin_test("random stream");
		load_coefs(rand_coef(), rand_coef(), rand_coef(), rand_coef(), rand_coef());
		for (i = 0; i < SAMPLE_COUNT; i++)
		begin
			send_sample(sample_t'($urandom), int'($urandom_range(3, 0)));
			need_output();
		end
		wait_done();
		end_test(3);
	endtask

	task automatic back_pressure();
		int  i;
		int  n_cr;
		int  n_ov;
		bit  seen;
		bit  stalled;
		begin_test("back-pressure");
		load_coefs(rand_coef(), rand_coef(), rand_coef(), rand_coef(), rand_coef());
		credit_on <= 1'b0;
		stalled = 1'b0;
		// held credits run out within OUT_CREDITS + 1 samples
		for (i = 0; i <= OUT_CREDITS && !stalled; i++)
		begin
			send_sample(sample_t'($urandom), 0);
			wait_output(WAIT_LIMIT, seen);
			stalled = !seen;
		end
		check_flag("output stalls without credit", 1'b1, stalled);
		n_cr = 0;
		n_ov = 0;
		repeat (50)
		begin
			@(negedge clk);
			n_cr += in_credit;
			n_ov += out_valid;
		end
		check_flag("no out_valid while stalled", 1'b0, n_ov != 0);
		check_flag("no in_credit while stalled", 1'b0, n_cr != 0);
		credit_on <= 1'b1;
		need_output();
		for (i = 0; i < 2; i++)
		begin
			send_sample(sample_t'($urandom), 1);
			need_output();
		end
		end_test(4);
	endtask

	task automatic sample_budget();
		int i;
		int n_cr;
		int n_dn;
		bit seen;
		begin_test("sample budget");
		load_coefs(rand_coef(), rand_coef(), rand_coef(), rand_coef(), rand_coef());
		for (i = 0; i < SAMPLE_COUNT; i++)
		begin
			send_sample(sample_t'($urandom), 0);
			need_output();
		end
		n_cr = 0;
		n_dn = 0;
		repeat (30)
		begin
			@(negedge clk);
			n_cr += in_credit;
			n_dn += done;
		end
		check_flag("one done pulse", 1'b1, n_dn == 1);
		check_flag("no in_credit after done", 1'b0, n_cr != 0);
		// idle filter must ignore a sample offered without credit
		@(negedge clk);
		in_valid = 1'b1;
		in_data = 8'sd55;
		@(negedge clk);
		in_valid = 1'b0;
		in_data = '0;
		wait_output(20, seen);
		check_flag("in_valid without credit ignored", 1'b0, seen);
		end_test(5);
	endtask

	task automatic reload_history();
		int    i;
		coef_t c[NUM_COEFS];
		begin_test("reload clears history");
		for (i = 0; i < NUM_COEFS; i++)
			c[i] = rand_coef();
		load_coefs(c[0], c[1], c[2], c[3], c[4]);
		for (i = 0; i < 3; i++)
		begin
			send_sample(sample_t'($urandom), 0);
			need_output();
		end
		// same coefficients again, model history restarts from zero
		load_coefs(c[0], c[1], c[2], c[3], c[4]);
		for (i = 0; i < 2; i++)
		begin
			send_sample(sample_t'($urandom), 2);
			need_output();
		end
		end_test(6);
	endtask

	initial
	begin
		void'($urandom(32'h3c3a_972e));
		reset = 1'b1;
		coef_load = 1'b0;
		coef = '0;
		in_valid = 1'b0;
		in_data = '0;
		credit_on = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_bad = 0;
		credit_held = 1'b0;
		timed_out = 1'b0;
		test_name = "reset";
		repeat (4) @(negedge clk);
		reset = 1'b0;

		quiet_after_reset();
		if (!timed_out)
			impulse_response();
		if (!timed_out)
			random_stream();
		if (!timed_out)
			back_pressure();
		if (!timed_out)
			sample_budget();
		if (!timed_out)
			reload_history();

		$display("summary: %0d tests run, %0d with errors, %0d checks, %0d errors",
			tests_run, tests_bad, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
